//--- verilog.f
+incdir+.
chip_pkg.sv
wb_if.sv
wb_decode.sv
scratch_ram.sv
uart_lite.sv
spi_master.sv
chip_top.sv
tb.sv

//--- Makefile
# Verilator build and run for the chip testbench

VERILATOR       ?= verilator
FILELIST        ?= verilog.f
TOP             ?= tb
OBJ_DIR         ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_table.svh
// testbench step type, register addresses and the stimulus and expected-value table
`ifndef TB_TABLE_SVH
`define TB_TABLE_SVH

typedef enum logic [1:0] {op_write, op_read, op_poll} op_e;

// for writes, expected is the least number of cycles to ack
typedef struct {
   op_e   op;
   addr_t addr;
   word_t data;
   sel_t  sel;
   word_t expected;
   word_t mask;
} tb_entry_t;

localparam addr_t uart_data_adr = uart_base + 16'h0;
localparam addr_t uart_stat_adr = uart_base + 16'h4;
localparam addr_t uart_ctrl_adr = uart_base + 16'h8;
localparam addr_t spi_data_adr  = spi_base + 16'h0;
localparam addr_t spi_stat_adr  = spi_base + 16'h4;
localparam addr_t spi_ctrl_adr  = spi_base + 16'h8;
localparam int    n_steps       = 33;

// ram data and ram expected values are filled in before the run
tb_entry_t steps [n_steps] = '{
   '{op_read,  uart_stat_adr, 32'h0, 4'hf, 32'h0, 32'hffff_ffff},
   '{op_read,  spi_stat_adr,  32'h0, 4'hf, 32'h0, 32'hffff_ffff},
   '{op_read,  uart_ctrl_adr, 32'h0, 4'hf, {16'd0, uart_div_reset}, 32'hffff_ffff},
   '{op_write, 16'h0000, 32'h0, 4'hf, 32'h0, 32'h0},
   '{op_write, 16'h0004, 32'h0, 4'hf, 32'h0, 32'h0},
   '{op_write, 16'h0010, 32'h0, 4'hf, 32'h0, 32'h0},
   '{op_write, 16'h03fc, 32'h0, 4'hf, 32'h0, 32'h0},  // last ram word
   '{op_write, 16'h0004, 32'h0, 4'h2, 32'h0, 32'h0},
   '{op_write, 16'h0010, 32'h0, 4'h9, 32'h0, 32'h0},
   '{op_read,  16'h0000, 32'h0, 4'hf, 32'h0, 32'hffff_ffff},
   '{op_read,  16'h0004, 32'h0, 4'hf, 32'h0, 32'hffff_ffff},
   '{op_read,  16'h0010, 32'h0, 4'hf, 32'h0, 32'hffff_ffff},
   '{op_read,  16'h03fc, 32'h0, 4'hf, 32'h0, 32'hffff_ffff},
   '{op_read,  16'h0400, 32'h0, 4'hf, 32'h0, 32'hffff_ffff},  // just past the ram
   '{op_write, 16'h3000, 32'hdead_beef, 4'hf, 32'h0, 32'h0},
   '{op_read,  16'h3000, 32'h0, 4'hf, 32'h0, 32'hffff_ffff},
   '{op_write, uart_ctrl_adr, 32'h4, 4'hf, 32'h0, 32'h0},
   '{op_write, uart_data_adr, 32'ha5, 4'hf, 32'h0, 32'h0},
   '{op_poll,  uart_stat_adr, 32'h0, 4'hf, 32'h2, 32'h2},
   '{op_read,  uart_data_adr, 32'h0, 4'hf, 32'ha5, 32'hffff_ffff},
   '{op_read,  uart_stat_adr, 32'h0, 4'hf, 32'h0, 32'hffff_ffff},
   '{op_write, uart_data_adr, 32'h3c, 4'hf, 32'h0, 32'h0},
   '{op_write, uart_data_adr, 32'hc3, 4'hf, 32'd36, 32'h0},  // waits out the first frame
   '{op_poll,  uart_stat_adr, 32'h0, 4'hf, 32'h4, 32'h4},
   '{op_read,  uart_stat_adr, 32'h0, 4'hf, 32'h6, 32'hffff_ffff},
   '{op_read,  uart_data_adr, 32'h0, 4'hf, 32'h3c, 32'hffff_ffff},
   '{op_read,  uart_stat_adr, 32'h0, 4'hf, 32'h0, 32'hffff_ffff},
   '{op_write, spi_ctrl_adr, 32'h20, 4'hf, 32'h0, 32'h0},  // cs low, half period 2
   '{op_write, spi_data_adr, 32'h96, 4'hf, 32'h0, 32'h0},
   '{op_poll,  spi_stat_adr, 32'h0, 4'hf, 32'h0, 32'h1},
   '{op_read,  spi_data_adr, 32'h0, 4'hf, 32'h96, 32'hffff_ffff},
   '{op_write, spi_ctrl_adr, 32'h41, 4'hf, 32'h0, 32'h0},
   '{op_read,  spi_ctrl_adr, 32'h0, 4'hf, 32'h41, 32'hffff_ffff}
};

`endif

//--- tb.sv
// testbench for chip_top with clock, reset, serial loopback, bus tasks, checks and table run
`timescale 1ns/1ps

module tb import chip_pkg::*; ();

   localparam int    ack_limit  = 2000;
   localparam int    poll_limit = 20000;
   localparam addr_t ram_limit  = ram_base + addr_t'(ram_words * 4);

   logic  clk = 1'b0;
   logic  rst_n;
   logic  wb_cyc, wb_stb, wb_we;
   addr_t wb_adr;
   word_t wb_dat_w, wb_dat_r;
   sel_t  wb_sel;
   logic  wb_ack;
   logic  rxd, txd, spi_miso, spi_cs, spi_sclk, spi_mosi;
   int    checks = 0;
   int    errors = 0;
   int    timeouts = 0;
   int    cycle_no = 0;
   int    sclk_rises = 0;
   integer seed = 32'hfc52c464;

   `include "tb_table.svh"

   always #4 clk = ~clk;
   always @(posedge clk) cycle_no++;

   always @(posedge spi_sclk) begin
      if (rst_n === 1'b1) sclk_rises++;  // one rise per spi bit
   end

   assign rxd      = txd;  // serial loopback
   assign spi_miso = spi_cs ? 1'b1 : spi_mosi;

   chip_top DUT (.*);

   task automatic check_word(input word_t got, input word_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_status(input uart_status_t got, input uart_status_t exp,
                               input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got busy %b valid %b overrun %b, expected %b%b%b",
                  $time, what, got.tx_busy, got.rx_valid, got.rx_overrun,
                  exp.tx_busy, exp.rx_valid, exp.rx_overrun);
      end
   endtask

   task automatic check_latency(input int got, input int least, input string what);
      checks++;
      if (got < least) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, ack after %0d cycles, expected at least %0d",
                  $time, what, got, least);
      end
   endtask

   // new word with only the selected byte lanes taken over
   function automatic word_t merge_lanes(word_t old, word_t nw, sel_t sel);
      word_t r;
      r = old;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) r[8*b +: 8] = nw[8*b +: 8];
      end
      return r;
   endfunction

   task automatic wait_ack(input addr_t adr, output word_t rd, output int cycles);
      for (cycles = 1; cycles <= ack_limit; cycles++) begin
         @(posedge clk);
         #1;
         if (wb_ack === 1'b1) break;
      end
      if (cycles > ack_limit) begin
         timeouts++;
         $display("timeout: no ack from address %h after %0d cycles", adr, ack_limit);
      end
      rd     = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input addr_t adr, input word_t dat, input sel_t sel,
                           output int cycles);
      word_t unused;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = adr;
      wb_dat_w = dat;
      wb_sel   = sel;
      wait_ack(adr, unused, cycles);
   endtask

   task automatic wb_read(input addr_t adr, output word_t rd);
      int cycles;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = adr;
      wb_sel = 4'hf;
      wait_ack(adr, rd, cycles);
   endtask

   task automatic poll_reg(input addr_t adr, input word_t exp, input word_t mask);
      word_t rd;
      int    t0;
      t0 = cycle_no;
      wb_read(adr, rd);
      while ((rd & mask) !== (exp & mask) && cycle_no - t0 < poll_limit) wb_read(adr, rd);
      if ((rd & mask) !== (exp & mask)) begin
         timeouts++;
         $display("timeout: register %h never reached %h under mask %h", adr, exp, mask);
      end
   endtask

   // random ram words and a shadow copy for the read-back values
   task automatic fill_ram_data();
      word_t shadow [addr_t];
      word_t old;
      for (int i = 0; i < n_steps; i++) begin
         if (steps[i].addr < ram_limit) begin
            if (steps[i].op == op_write) begin
               old = shadow.exists(steps[i].addr) ? shadow[steps[i].addr] : '0;
               steps[i].data = $random(seed);
               shadow[steps[i].addr] = merge_lanes(old, steps[i].data, steps[i].sel);
            end else if (shadow.exists(steps[i].addr)) begin
               steps[i].expected = shadow[steps[i].addr];
            end
         end
      end
   endtask

   task automatic run_step(input int i);
      word_t rd;
      int    cycles;
      string what;
      what = $sformatf("step %0d at %h", i, steps[i].addr);
      case (steps[i].op)
         op_write: begin
            wb_write(steps[i].addr, steps[i].data, steps[i].sel, cycles);
            if (steps[i].expected != 0) check_latency(cycles, int'(steps[i].expected), what);
         end
         op_read: begin
            wb_read(steps[i].addr, rd);
            if (steps[i].addr == uart_stat_adr)
               check_status(uart_status_t'(rd[2:0]), uart_status_t'(steps[i].expected[2:0]),
                            what);
            else
               check_word(rd & steps[i].mask, steps[i].expected & steps[i].mask, what);
         end
         default: poll_reg(steps[i].addr, steps[i].expected, steps[i].mask);
      endcase
   endtask

   initial begin
      rst_n    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      wb_sel   = '0;
      fill_ram_data();
      repeat (4) @(posedge clk);
      #1 rst_n = 1'b1;
      check_word({31'd0, txd}, 32'd1, "txd idle after reset");
      check_word({31'd0, spi_cs}, 32'd1, "spi_cs high after reset");
      check_word({31'd0, spi_sclk}, 32'd0, "spi_sclk low after reset");
      check_word({31'd0, spi_mosi}, 32'd0, "spi_mosi low after reset");
      for (int i = 0; i < n_steps; i++) run_step(i);
      check_word({31'd0, spi_cs}, 32'd1, "spi_cs high after ctrl write");
      check_word(word_t'(sclk_rises), 32'd8, "sclk rising edges for one spi byte");
      $display("checks run %0d, failed %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- chip_top.sv
// chip top level with host wishbone port, address decoder, scratch ram, uart and spi
`timescale 1ns/1ps

module chip_top import chip_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  wb_cyc,
   input  logic  wb_stb,
   input  logic  wb_we,
   input  addr_t wb_adr,
   input  word_t wb_dat_w,
   input  sel_t  wb_sel,
   output word_t wb_dat_r,
   output logic  wb_ack,
   input  logic  rxd,
   output logic  txd,
   input  logic  spi_miso,
   output logic  spi_cs,
   output logic  spi_sclk,
   output logic  spi_mosi
);

   wb_if host_bus ();
   wb_if ram_bus ();
   wb_if uart_bus ();
   wb_if spi_bus ();

   // host pins into the decoder bundle
   assign host_bus.cyc   = wb_cyc;
   assign host_bus.stb   = wb_stb;
   assign host_bus.we    = wb_we;
   assign host_bus.adr   = wb_adr;
   assign host_bus.dat_w = wb_dat_w;
   assign host_bus.sel   = wb_sel;
   assign wb_dat_r       = host_bus.dat_r;
   assign wb_ack         = host_bus.ack;

   wb_decode u_decode (
      .clk   (clk),
      .rst_n (rst_n),
      .host  (host_bus.slave),
      .ram   (ram_bus.master),
      .uart  (uart_bus.master),
      .spi   (spi_bus.master)
   );

   scratch_ram u_ram (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (ram_bus.slave)
   );

   uart_lite u_uart (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (uart_bus.slave),
      .rxd   (rxd),
      .txd   (txd)
   );

   spi_master u_spi (
      .clk      (clk),
      .rst_n    (rst_n),
      .bus      (spi_bus.slave),
      .spi_miso (spi_miso),
      .spi_cs   (spi_cs),
      .spi_sclk (spi_sclk),
      .spi_mosi (spi_mosi)
   );

endmodule

//--- spi_master.sv
// spi mode 0 master with data, status and control registers
`timescale 1ns/1ps

module spi_master import chip_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   wb_if.slave  bus,
   input  logic spi_miso,
   output logic spi_cs,
   output logic spi_sclk,
   output logic spi_mosi
);

   spi_state_e state;
   logic [3:0] half_q, cnt;
   logic [2:0] bit_cnt;
   logic [7:0] tx_sh, rx_sh, rx_q;
   logic       cs_q, ack_q, busy;
   logic       req, accept, go, tick;
   word_t      rd_q;
   reg_e       off;

   assign off    = reg_e'(bus.adr[3:2]);
   assign busy   = (state != spi_idle);
   assign req    = bus.cyc & bus.stb & ~ack_q;
   assign accept = req & ~(bus.we & (off == reg_data) & busy);  // hold off data write
   assign go     = accept & bus.we & (off == reg_data);
   assign tick   = (cnt == half_q - 4'd1);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_q  <= 1'b0;
         cs_q   <= 1'b1;
         half_q <= spi_div_reset;
      end else begin
         ack_q <= accept;
         if (accept && bus.we && off == reg_ctrl) begin
            cs_q   <= bus.dat_w[0];
            half_q <= bus.dat_w[7:4];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && !bus.we) begin
         case (off)
            reg_data:   rd_q <= {24'd0, rx_q};
            reg_status: rd_q <= {31'd0, busy};
            reg_ctrl:   rd_q <= {24'd0, half_q, 3'd0, cs_q};
            default:    rd_q <= '0;
         endcase
      end
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = rd_q;

   // shift engine, one low and one high phase per bit
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= spi_idle;
         cnt     <= '0;
         bit_cnt <= '0;
      end else if (state == spi_idle) begin
         cnt     <= '0;
         bit_cnt <= '0;
         if (go) state <= spi_low;
      end else begin
         cnt <= tick ? '0 : cnt + 4'd1;
         if (tick) begin
            if (state == spi_low) begin
               state <= spi_high;
            end else begin
               bit_cnt <= bit_cnt + 3'd1;
               state   <= (bit_cnt == 3'd7) ? spi_idle : spi_low;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (go) tx_sh <= bus.dat_w[7:0];
      else if (state == spi_high && tick) tx_sh <= {tx_sh[6:0], 1'b0};  // falling edge
      if (state == spi_low && tick) rx_sh <= {rx_sh[6:0], spi_miso};     // rising edge
      if (state == spi_high && tick && bit_cnt == 3'd7) rx_q <= rx_sh;
   end

   assign spi_cs   = cs_q;
   assign spi_sclk = (state == spi_high);
   assign spi_mosi = busy & tx_sh[7];  // msb first

endmodule

//--- uart_lite.sv
// uart 8n1 transmitter and receiver with data, status and divisor registers
`timescale 1ns/1ps

module uart_lite import chip_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   wb_if.slave  bus,
   input  logic rxd,
   output logic txd
);

   uart_state_e  tx_state, rx_state;
   logic [15:0]  div_q, tx_cnt, rx_cnt;
   logic [2:0]   tx_bit, rx_bit;
   logic [7:0]   tx_sh, rx_sh, hold_q;
   logic         rx_s1, rx_s2, rx_done;
   logic         rx_valid_q, ovr_q, ack_q;
   logic         req, accept, tx_go, pop, tx_tick, rx_tick;
   word_t        rd_q;
   uart_status_t st;
   reg_e         off;

   always_comb begin
      st.tx_busy    = (tx_state != uart_idle);
      st.rx_valid   = rx_valid_q;
      st.rx_overrun = ovr_q;
   end

   assign off     = reg_e'(bus.adr[3:2]);
   assign req     = bus.cyc & bus.stb & ~ack_q;
   assign accept  = req & ~(bus.we & (off == reg_data) & st.tx_busy);  // tx back-pressure
   assign tx_go   = accept & bus.we & (off == reg_data);
   assign pop     = accept & ~bus.we & (off == reg_data);
   assign tx_tick = (tx_cnt == div_q - 16'd1);
   assign rx_tick = (rx_cnt == div_q - 16'd1);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
         div_q <= uart_div_reset;
      end else begin
         ack_q <= accept;
         if (accept && bus.we && off == reg_ctrl) div_q <= bus.dat_w[15:0];
      end
   end

   always_ff @(posedge clk) begin
      if (accept && !bus.we) begin
         case (off)
            reg_data:   rd_q <= {24'd0, hold_q};
            reg_status: rd_q <= {29'd0, st};
            reg_ctrl:   rd_q <= {16'd0, div_q};
            default:    rd_q <= '0;
         endcase
      end
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = rd_q;

   // transmitter
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_state <= uart_idle;
         tx_cnt   <= '0;
         tx_bit   <= '0;
      end else if (tx_state == uart_idle) begin
         tx_cnt <= '0;
         tx_bit <= '0;
         if (tx_go) tx_state <= uart_start;
      end else begin
         tx_cnt <= tx_tick ? '0 : tx_cnt + 16'd1;
         if (tx_tick) begin
            case (tx_state)
               uart_start: tx_state <= uart_data;
               uart_data: begin
                  tx_bit <= tx_bit + 3'd1;
                  if (tx_bit == 3'd7) tx_state <= uart_stop;
               end
               default: tx_state <= uart_idle;  // end of stop bit
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (tx_go) tx_sh <= bus.dat_w[7:0];
      else if (tx_state == uart_data && tx_tick) tx_sh <= tx_sh >> 1;  // lsb first
   end

   assign txd = (tx_state == uart_start) ? 1'b0 :
                (tx_state == uart_data)  ? tx_sh[0] : 1'b1;

   // receiver
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_s1 <= 1'b1;
         rx_s2 <= 1'b1;
      end else begin
         rx_s1 <= rxd;
         rx_s2 <= rx_s1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_state <= uart_idle;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_done  <= 1'b0;
      end else begin
         rx_done <= 1'b0;
         rx_cnt  <= rx_cnt + 16'd1;
         case (rx_state)
            uart_idle: begin
               rx_cnt <= '0;
               rx_bit <= '0;
               if (!rx_s2) rx_state <= uart_start;
            end
            uart_start: if (rx_cnt == {1'b0, div_q[15:1]}) begin  // mid start bit
               rx_cnt   <= '0;
               rx_state <= rx_s2 ? uart_idle : uart_data;      // glitch, back to idle
            end
            uart_data: if (rx_tick) begin
               rx_cnt <= '0;
               rx_bit <= rx_bit + 3'd1;
               if (rx_bit == 3'd7) rx_state <= uart_stop;
            end
            default: if (rx_tick) begin
               rx_state <= uart_idle;
               rx_done  <= rx_s2;  // drop frames with a bad stop bit
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rx_state == uart_data && rx_tick) rx_sh <= {rx_s2, rx_sh[7:1]};
      if (rx_done && (!rx_valid_q || pop)) hold_q <= rx_sh;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_valid_q <= 1'b0;
         ovr_q      <= 1'b0;
      end else begin
         if (pop) begin
            rx_valid_q <= 1'b0;
            ovr_q      <= 1'b0;
         end
         if (rx_done) begin
            if (rx_valid_q && !pop) ovr_q <= 1'b1;  // new byte lost
            else rx_valid_q <= 1'b1;
         end
      end
   end

endmodule

//--- scratch_ram.sv
// scratch ram, 256 words with byte-lane writes on a wishbone slave port
`timescale 1ns/1ps

module scratch_ram import chip_pkg::*; (
   input logic clk,
   input logic rst_n,
   wb_if.slave bus
);

   word_t      mem [ram_words];
   word_t      rd_q;
   logic       ack_q;
   logic       req;
   logic [7:0] idx;

   assign idx = bus.adr[9:2];
   assign req = bus.cyc & bus.stb & ~ack_q;  // no second ack for a held stb

   always_ff @(posedge clk) begin
      if (!rst_n) ack_q <= 1'b0;
      else        ack_q <= req;
   end

   always_ff @(posedge clk) begin
      if (req) begin
         if (bus.we) begin
            for (int i = 0; i < data_w / 8; i++) begin
               if (bus.sel[i]) mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
            end
         end else begin
            rd_q <= mem[idx];
         end
      end
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = rd_q;

endmodule

//--- wb_decode.sv
// wishbone address decoder with target select, read mux and unmapped acknowledge
`timescale 1ns/1ps

module wb_decode import chip_pkg::*; (
   input logic clk,
   input logic rst_n,
   wb_if.slave  host,
   wb_if.master ram,
   wb_if.master uart,
   wb_if.master spi
);

   target_e tgt;
   logic    none_ack_q;

   function automatic target_e classify(addr_t a);
      target_e t;
      t = tgt_none;
      if (a[15:14] == 2'b00) begin
         case (a[13:12])
            ram_base[13:12]:  if (int'(a[11:0]) < ram_words * 4) t = tgt_ram;
            uart_base[13:12]: t = tgt_uart;
            spi_base[13:12]:  t = tgt_spi;
            default:          t = tgt_none;
         endcase
      end
      return t;
   endfunction

   assign tgt = classify(host.adr);

   // shared lines go to every target, only stb is steered
   assign ram.cyc    = host.cyc;
   assign ram.we     = host.we;
   assign ram.adr    = host.adr;
   assign ram.dat_w  = host.dat_w;
   assign ram.sel    = host.sel;
   assign ram.stb    = host.stb & (tgt == tgt_ram);

   assign uart.cyc   = host.cyc;
   assign uart.we    = host.we;
   assign uart.adr   = host.adr;
   assign uart.dat_w = host.dat_w;
   assign uart.sel   = host.sel;
   assign uart.stb   = host.stb & (tgt == tgt_uart);

   assign spi.cyc    = host.cyc;
   assign spi.we     = host.we;
   assign spi.adr    = host.adr;
   assign spi.dat_w  = host.dat_w;
   assign spi.sel    = host.sel;
   assign spi.stb    = host.stb & (tgt == tgt_spi);

   // stray access, ack next cycle so the host never hangs
   always_ff @(posedge clk) begin
      if (!rst_n) none_ack_q <= 1'b0;
      else        none_ack_q <= host.cyc & host.stb & (tgt == tgt_none) & ~none_ack_q;
   end

   always_comb begin
      case (tgt)
         tgt_ram:  begin host.dat_r = ram.dat_r;  host.ack = ram.ack;  end
         tgt_uart: begin host.dat_r = uart.dat_r; host.ack = uart.ack; end
         tgt_spi:  begin host.dat_r = spi.dat_r;  host.ack = spi.ack;  end
         default:  begin host.dat_r = '0;         host.ack = none_ack_q; end
      endcase
   end

endmodule

//--- wb_if.sv
// wishbone classic bus bundle with master and slave modports
`timescale 1ns/1ps

interface wb_if import chip_pkg::*; ();

   logic  cyc;
   logic  stb;
   logic  we;
   addr_t adr;
   word_t dat_w;
   sel_t  sel;
   word_t dat_r;
   logic  ack;

   modport master (
      output cyc, stb, we, adr, dat_w, sel,
      input  dat_r, ack
   );

   modport slave (
      input  cyc, stb, we, adr, dat_w, sel,
      output dat_r, ack
   );

endinterface

//--- chip_pkg.sv
// bus widths, word types, address map, reset values, enums and uart status struct
package chip_pkg;

   localparam int addr_w = 16;
   localparam int data_w = 32;

   typedef logic [data_w-1:0]   word_t;
   typedef logic [addr_w-1:0]   addr_t;
   typedef logic [data_w/8-1:0] sel_t;

   // address map, each target owns one 4k page
   localparam addr_t ram_base  = 16'h0000;
   localparam int    ram_words = 256;
   localparam addr_t uart_base = 16'h1000;
   localparam addr_t spi_base  = 16'h2000;

   localparam logic [15:0] uart_div_reset = 16'd16;  // clk cycles per bit
   localparam logic [3:0]  spi_div_reset  = 4'd4;    // clk cycles per sclk half

   typedef enum logic [1:0] {tgt_ram, tgt_uart, tgt_spi, tgt_none} target_e;

   // peripheral register offset, adr[3:2]
   typedef enum logic [1:0] {
      reg_data   = 2'd0,
      reg_status = 2'd1,
      reg_ctrl   = 2'd2
   } reg_e;

   typedef enum logic [1:0] {uart_idle, uart_start, uart_data, uart_stop} uart_state_e;
   typedef enum logic [1:0] {spi_idle, spi_low, spi_high} spi_state_e;

   // tx_busy lands in bit 0 of the status word
   typedef struct packed {
      logic rx_overrun;
      logic rx_valid;
      logic tx_busy;
   } uart_status_t;

endpackage
